/* build.f */
+incdir+include
design/rv_core_pkg.sv
design/bypass_if.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/rv_core.sv
tb/rv_core_chk.sv
tb/rv_core_tb.sv

/* design/bypass_if.sv */
//////////////////////////////
// pending register result of
// one stage, seen by decode
//////////////////////////////
`timescale 1ns/1ns

interface bypass_if;
    import rv_core_pkg::*;

    logic     valid;
    logic     we;
    reg_idx_t rd;
    xlen_t    data;

    modport src  (output valid, output we, output rd, output data);
    modport sink (input valid, input we, input rd, input data);

endinterface

/* design/decode_stage.sv */
//////////////////////////////
// instruction decode, imm gen
// operand forwarding
//////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module decode_stage (
    input  logic                    fd_valid,
    input  rv_core_pkg::fetch_pkt_t fd_pkt,
    output rv_core_pkg::reg_idx_t   rs1,
    output rv_core_pkg::reg_idx_t   rs2,
    input  rv_core_pkg::xlen_t      rs1_data,
    input  rv_core_pkg::xlen_t      rs2_data,
    bypass_if.sink                  byp_exe,
    bypass_if.sink                  byp_wb,
    output logic                    de_valid,
    output rv_core_pkg::dec_pkt_t   de_pkt
);
    import rv_core_pkg::*;

    logic [`RV_ILEN-1:0] inst;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    reg_idx_t            rd;
    logic                legal;
    logic                use_imm;
    logic                alt;
    alu_op_e             alu_op;
    xlen_t               imm;
    logic                exe_ok;
    logic                wb_ok;
    xlen_t               fwd_a;
    xlen_t               fwd_b;

    // youngest producer wins
    function automatic xlen_t select_src(
        input reg_idx_t idx,
        input xlen_t    rf_data,
        input logic     exe_hit_ok,
        input reg_idx_t exe_rd,
        input xlen_t    exe_data,
        input logic     wb_hit_ok,
        input reg_idx_t wb_rd,
        input xlen_t    wb_data
    );
        xlen_t val;
        if (exe_hit_ok && exe_rd == idx) begin
            val = exe_data;
        end else if (wb_hit_ok && wb_rd == idx) begin
            val = wb_data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign inst   = fd_pkt.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b1;
        alt     = 1'b0;
        imm     = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
        case (opcode)
            `RV_OPC_OP: begin
                use_imm = 1'b0;
                alt     = funct7[5];
                legal   = (funct7 == 7'b0000000) ||
                          (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `RV_OPC_OP_IMM: begin
                // shifts carry a 6-bit shamt, bit 30 picks sra
                alt = (funct3 == 3'b101) && inst[30];
                if (funct3 == 3'b001) begin
                    legal = (inst[31:26] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    legal = (inst[31:26] == 6'b000000) || (inst[31:26] == 6'b010000);
                end else begin
                    legal = 1'b1;
                end
            end
            `RV_OPC_LUI: begin
                legal = 1'b1;
                imm   = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'h000};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (opcode == `RV_OPC_LUI) begin
            alu_op = ALU_PASS_B;
        end
    end

    // a source counts only with a real destination
    assign exe_ok = byp_exe.valid && byp_exe.we && (byp_exe.rd != '0);
    assign wb_ok  = byp_wb.valid && byp_wb.we && (byp_wb.rd != '0);

    assign fwd_a = select_src(rs1, rs1_data, exe_ok, byp_exe.rd, byp_exe.data,
                              wb_ok, byp_wb.rd, byp_wb.data);
    assign fwd_b = select_src(rs2, rs2_data, exe_ok, byp_exe.rd, byp_exe.data,
                              wb_ok, byp_wb.rd, byp_wb.data);

    assign de_valid      = fd_valid;
    assign de_pkt.pc     = fd_pkt.pc;
    assign de_pkt.inst   = inst;
    assign de_pkt.rd     = rd;
    assign de_pkt.we     = legal && (rd != '0);
    assign de_pkt.alu_op = alu_op;
    assign de_pkt.a      = fwd_a;
    assign de_pkt.b      = use_imm ? imm : fwd_b;

endmodule

/* design/execute_stage.sv */
//////////////////////////////
// 64-bit alu and execute
// stage bypass source
//////////////////////////////
`timescale 1ns/1ns

module execute_stage (
    input  logic                  de_valid,
    input  rv_core_pkg::dec_pkt_t de_pkt,
    bypass_if.src                 byp_exe,
    output logic                  ex_valid,
    output rv_core_pkg::wb_pkt_t  ex_pkt
);
    import rv_core_pkg::*;

    xlen_t      a;
    xlen_t      b;
    logic [5:0] shamt;
    xlen_t      result;

    assign a     = de_pkt.a;
    assign b     = de_pkt.b;
    assign shamt = b[5:0];

    always_comb begin
        case (de_pkt.alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU:   result = xlen_t'(a < b);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // same-cycle result for the instruction in decode
    assign byp_exe.valid = de_valid;
    assign byp_exe.we    = de_pkt.we;
    assign byp_exe.rd    = de_pkt.rd;
    assign byp_exe.data  = result;

    assign ex_valid      = de_valid;
    assign ex_pkt.pc     = de_pkt.pc;
    assign ex_pkt.inst   = de_pkt.inst;
    assign ex_pkt.rd     = de_pkt.rd;
    assign ex_pkt.we     = de_pkt.we;
    assign ex_pkt.result = result;

endmodule

/* design/fetch_stage.sv */
//////////////////////////////
// program counter and fetch
// packet with stall handling
//////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module fetch_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    if_stall,
    input  logic [`RV_ILEN-1:0]     inst,
    output rv_core_pkg::xlen_t      pc,
    output logic                    fetch_valid,
    output rv_core_pkg::fetch_pkt_t fetch_pkt
);
    import rv_core_pkg::*;

    xlen_t pc_q;

    // hold on stall, else next word
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `RV_RESET_PC;
        end else if (!if_stall) begin
            pc_q <= pc_q + xlen_t'(4);
        end
    end

    assign pc = pc_q;

    // stalled cycle sends a bubble
    assign fetch_valid    = !if_stall;
    assign fetch_pkt.pc   = pc_q;
    assign fetch_pkt.inst = inst;

endmodule

/* design/pipe_reg.sv */
//////////////////////////////
// stage register, any payload
// with its own valid bit
//////////////////////////////
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_pkt,
    output logic     out_valid,
    output payload_t out_pkt
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // a bubble leaves the last payload in place
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_pkt <= in_pkt;
        end
    end

endmodule

/* design/reg_file.sv */
//////////////////////////////
// 32 x 64 register file
// two read ports, one write
//////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    output rv_core_pkg::xlen_t    rs1_data,
    output rv_core_pkg::xlen_t    rs2_data,
    input  logic                  we,
    input  rv_core_pkg::reg_idx_t rd,
    input  rv_core_pkg::xlen_t    rd_data
);
    import rv_core_pkg::*;

    xlen_t regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/rv_core.sv */
//////////////////////////////
// four-stage rv64i core top
// stage wiring, commit trace
//////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 rst,
    output logic [`RV_XLEN-1:0]  pc,
    input  logic [`RV_ILEN-1:0]  inst,
    input  logic                 if_stall,
    output logic                 commit_valid,
    output logic [`RV_XLEN-1:0]  commit_pc,
    output logic [`RV_ILEN-1:0]  commit_inst,
    output logic                 commit_rd_we,
    output logic [`RV_REG_W-1:0] commit_rd_id,
    output logic [`RV_XLEN-1:0]  commit_rd_data
);
    import rv_core_pkg::*;

    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       fd_valid;
    fetch_pkt_t fd_pkt;
    logic       dec_valid;
    dec_pkt_t   dec_pkt;
    logic       de_valid;
    dec_pkt_t   de_pkt;
    logic       ex_valid;
    wb_pkt_t    ex_pkt;
    logic       ew_valid;
    wb_pkt_t    ew_pkt;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      rs1_data;
    xlen_t      rs2_data;

    bypass_if byp_exe ();
    bypass_if byp_wb ();

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .if_stall   (if_stall),
        .inst       (inst),
        .pc         (pc),
        .fetch_valid(fetch_valid),
        .fetch_pkt  (fetch_pkt)
    );

    pipe_reg #(.payload_t(fetch_pkt_t)) u_fd_reg (
        .clk      (clk),
        .rst      (rst),
        .in_valid (fetch_valid),
        .in_pkt   (fetch_pkt),
        .out_valid(fd_valid),
        .out_pkt  (fd_pkt)
    );

    decode_stage u_decode (
        .fd_valid(fd_valid),
        .fd_pkt  (fd_pkt),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .byp_exe (byp_exe),
        .byp_wb  (byp_wb),
        .de_valid(dec_valid),
        .de_pkt  (dec_pkt)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (commit_rd_we),
        .rd      (ew_pkt.rd),
        .rd_data (ew_pkt.result)
    );

    pipe_reg #(.payload_t(dec_pkt_t)) u_de_reg (
        .clk      (clk),
        .rst      (rst),
        .in_valid (dec_valid),
        .in_pkt   (dec_pkt),
        .out_valid(de_valid),
        .out_pkt  (de_pkt)
    );

    execute_stage u_execute (
        .de_valid(de_valid),
        .de_pkt  (de_pkt),
        .byp_exe (byp_exe),
        .ex_valid(ex_valid),
        .ex_pkt  (ex_pkt)
    );

    pipe_reg #(.payload_t(wb_pkt_t)) u_ew_reg (
        .clk      (clk),
        .rst      (rst),
        .in_valid (ex_valid),
        .in_pkt   (ex_pkt),
        .out_valid(ew_valid),
        .out_pkt  (ew_pkt)
    );

    // writeback result, written at the next edge
    assign byp_wb.valid = ew_valid;
    assign byp_wb.we    = ew_pkt.we;
    assign byp_wb.rd    = ew_pkt.rd;
    assign byp_wb.data  = ew_pkt.result;

    assign commit_valid   = ew_valid;
    assign commit_pc      = ew_pkt.pc;
    assign commit_inst    = ew_pkt.inst;
    assign commit_rd_we   = ew_valid && ew_pkt.we;
    assign commit_rd_id   = ew_pkt.rd;
    assign commit_rd_data = ew_pkt.result;

endmodule

/* design/rv_core_pkg.sv */
//////////////////////////////
// data word and index types
// alu operation enum
// stage payload structs
//////////////////////////////
`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]  xlen_t;
    typedef logic [`RV_REG_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        xlen_t               pc;
        logic [`RV_ILEN-1:0] inst;
    } fetch_pkt_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        xlen_t               pc;
        logic [`RV_ILEN-1:0] inst;
        reg_idx_t            rd;
        logic                we;
        alu_op_e             alu_op;
        xlen_t               a;
        xlen_t               b;
    } dec_pkt_t;

    // execute to writeback
    typedef struct packed {
        xlen_t               pc;
        logic [`RV_ILEN-1:0] inst;
        reg_idx_t            rd;
        logic                we;
        xlen_t               result;
    } wb_pkt_t;

endpackage

/* include/rv_core_defs.svh */
//////////////////////////////
// core widths, register count
// reset pc and major opcodes
//////////////////////////////
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data and instruction widths
`define RV_XLEN     64
`define RV_ILEN     32

// integer register file
`define RV_NREGS    32
`define RV_REG_W    5

`define RV_RESET_PC 64'h0000_0000_0000_0000

// supported major opcodes, inst[6:0]
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI    7'b0110111

`endif

/* tb/rv_core_chk.sv */
//////////////////////////////
// protocol assertions, bound
// to the core top level
//////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_core_chk (
    input logic                 clk,
    input logic                 rst,
    input logic [`RV_XLEN-1:0]  pc,
    input logic                 if_stall,
    input logic                 commit_valid,
    input logic [`RV_XLEN-1:0]  commit_pc,
    input logic                 commit_rd_we,
    input logic [`RV_REG_W-1:0] commit_rd_id
);

    int                  error_count = 0;
    logic [`RV_XLEN-1:0] next_commit_pc;

    // commits retire in program order
    always_ff @(posedge clk) begin
        if (rst) begin
            next_commit_pc <= `RV_RESET_PC;
        end else if (commit_valid) begin
            next_commit_pc <= commit_pc + 64'd4;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> (!commit_valid && !commit_rd_we && pc == `RV_RESET_PC))
        else begin
            error_count++;
            $error("core not idle at reset pc while in reset");
        end

    a_commit_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_pc == next_commit_pc)
        else begin
            error_count++;
            $error("commit pc out of sequence");
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        commit_rd_we |-> (commit_valid && commit_rd_id != '0))
        else begin
            error_count++;
            $error("register write to x0 or without a commit");
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (rst)
        !rst && if_stall |=> $stable(pc))
        else begin
            error_count++;
            $error("pc moved during a fetch stall");
        end

    a_pc_step: assert property (@(posedge clk) disable iff (rst)
        !rst && !if_stall |=> pc == $past(pc) + 64'd4)
        else begin
            error_count++;
            $error("pc did not step by 4 on an accepted fetch");
        end

endmodule

bind rv_core rv_core_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .if_stall    (if_stall),
    .commit_valid(commit_valid),
    .commit_pc   (commit_pc),
    .commit_rd_we(commit_rd_we),
    .commit_rd_id(commit_rd_id)
);

/* tb/rv_core_tb.sv */
//////////////////////////////
// rv64i core testbench
// random program, register model
// data assertions, end checks
//////////////////////////////
`timescale 1ns/1ns
`include "rv_core_defs.svh"

module rv_core_tb;

    localparam int          PROG_WORDS = 256;
    localparam logic [63:0] LAST_PC    = `RV_RESET_PC + 64'(4 * (PROG_WORDS - 1));
    // 256 words at up to ~4 cycles each, plus reset and margin
    localparam int          MAX_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic [63:0] pc;
    logic [31:0] inst;
    logic        if_stall;
    logic        commit_valid;
    logic [63:0] commit_pc;
    logic [31:0] commit_inst;
    logic        commit_rd_we;
    logic [4:0]  commit_rd_id;
    logic [63:0] commit_rd_data;

    integer      seed;
    logic [31:0] prog_mem [PROG_WORDS];
    logic [63:0] model_regs [32];
    logic [64:0] ref_out;
    logic        exp_we;
    logic [63:0] exp_val;
    int          accepted;
    int          committed;
    logic [2:0]  accept_hist;
    logic        last_seen;
    int          cycles;
    int          expected_commits;

    rv_core u_rv_core (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .inst          (inst),
        .if_stall      (if_stall),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_inst   (commit_inst),
        .commit_rd_we  (commit_rd_we),
        .commit_rd_id  (commit_rd_id),
        .commit_rd_data(commit_rd_data)
    );

    always #2 clk = ~clk;

    // instruction memory answers in the same cycle
    assign inst = prog_mem[pc[9:2]];

    task automatic abort_run(input string why);
        $display("ERRORS FOUND");
        $fatal(1, why);
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        abort_run("value mismatch on the commit trace");
    endtask

    // registers from x0-x7 so dependencies are close together
    task automatic fill_program;
        logic [31:0] r;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [11:0] imm;
        for (int i = 0; i < PROG_WORDS; i++) begin
            kind = 4'($random(seed));
            r    = $random(seed);
            rd   = {2'b00, r[2:0]};
            rs1  = {2'b00, r[5:3]};
            rs2  = {2'b00, r[8:6]};
            f3   = r[11:9];
            imm  = r[23:12];
            if (kind < 6) begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[24]) ? 7'b0100000 : 7'b0000000;
                prog_mem[i] = {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
            end else if (kind < 12) begin
                if (f3 == 3'b001) begin
                    imm = {6'b000000, r[17:12]};
                end else if (f3 == 3'b101) begin
                    imm = {r[24] ? 6'b010000 : 6'b000000, r[17:12]};
                end
                prog_mem[i] = {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
            end else if (kind < 14) begin
                prog_mem[i] = {r[31:12], rd, `RV_OPC_LUI};
            end else if (kind == 14) begin
                // load, store, branch, system
                case (r[25:24])
                    2'b00:   opc = 7'b0000011;
                    2'b01:   opc = 7'b0100011;
                    2'b10:   opc = 7'b1100011;
                    default: opc = 7'b1110011;
                endcase
                prog_mem[i] = {r[31:7], opc};
            end else begin
                prog_mem[i] = {imm, rs1, 3'b000, rd, `RV_OPC_OP_IMM};
            end
        end
    endtask

    // rv64i result with its legality bit on top
    function automatic logic [64:0] ref_exec(input logic [31:0] ins,
                                             input logic [63:0] x1,
                                             input logic [63:0] x2);
        logic [63:0] op2;
        logic [63:0] val;
        logic        alt;
        logic        ok;
        ok  = 1'b0;
        alt = 1'b0;
        op2 = {{52{ins[31]}}, ins[31:20]};
        if (ins[6:0] == `RV_OPC_OP) begin
            op2 = x2;
            alt = ins[30];
            ok  = (ins[31:25] == 7'b0000000) ||
                  (ins[31:25] == 7'b0100000 && (ins[14:12] == 3'b000 || ins[14:12] == 3'b101));
        end else if (ins[6:0] == `RV_OPC_OP_IMM) begin
            ok = 1'b1;
            if (ins[14:12] == 3'b001) begin
                ok = (ins[31:26] == 6'b000000);
            end else if (ins[14:12] == 3'b101) begin
                alt = ins[30];
                ok  = (ins[31:26] == 6'b000000) || (ins[31:26] == 6'b010000);
            end
        end
        case (ins[14:12])
            3'b000:  val = alt ? x1 - op2 : x1 + op2;
            3'b001:  val = x1 << op2[5:0];
            3'b010:  val = {63'd0, $signed(x1) < $signed(op2)};
            3'b011:  val = {63'd0, x1 < op2};
            3'b100:  val = x1 ^ op2;
            3'b110:  val = x1 | op2;
            3'b111:  val = x1 & op2;
            default: begin
                if (alt) begin
                    val = $signed(x1) >>> op2[5:0];
                end else begin
                    val = x1 >> op2[5:0];
                end
            end
        endcase
        if (ins[6:0] == `RV_OPC_LUI) begin
            ok  = 1'b1;
            val = {{32{ins[31]}}, ins[31:12], 12'h000};
        end
        return {ok, val};
    endfunction

    assign ref_out = ref_exec(commit_inst, model_regs[commit_inst[19:15]],
                              model_regs[commit_inst[24:20]]);
    assign exp_we  = ref_out[64] && (commit_inst[11:7] != 5'd0);
    assign exp_val = ref_out[63:0];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] <= '0;
            end
        end else if (commit_valid && exp_we) begin
            model_regs[commit_inst[11:7]] <= exp_val;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            if_stall <= 1'b0;
        end else begin
            if_stall <= ($random(seed) & 3) == 0;
        end
    end

    // accepted and retired counts and the last three accepts
    always @(posedge clk) begin
        if (rst) begin
            accepted    <= 0;
            committed   <= 0;
            accept_hist <= '0;
            last_seen   <= 1'b0;
        end else begin
            accepted    <= accepted + int'(!if_stall);
            accept_hist <= {accept_hist[1:0], !if_stall};
            committed   <= committed + int'(commit_valid);
            if (commit_valid && commit_pc == LAST_PC) begin
                last_seen <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= rst ? 0 : cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout: the last program word never committed");
        end
    end

    always @(posedge clk) begin
        if (u_rv_core.u_chk.error_count != 0) begin
            abort_run("the protocol checker reported a failed assertion");
        end
    end

    a_inst_word: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_inst == prog_mem[commit_pc[9:2]])
        else flag_mismatch("commit_inst", 64'(prog_mem[$sampled(commit_pc[9:2])]),
                           64'($sampled(commit_inst)));

    a_rd_we: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit_rd_we == exp_we)
        else flag_mismatch("commit_rd_we", 64'($sampled(exp_we)), 64'($sampled(commit_rd_we)));

    a_rd_id: assert property (@(posedge clk) disable iff (rst)
        commit_valid && exp_we |-> commit_rd_id == commit_inst[11:7])
        else flag_mismatch("commit_rd_id", 64'($sampled(commit_inst[11:7])),
                           64'($sampled(commit_rd_id)));

    a_rd_data: assert property (@(posedge clk) disable iff (rst)
        commit_valid && exp_we |-> commit_rd_data == exp_val)
        else flag_mismatch("commit_rd_data", $sampled(exp_val), $sampled(commit_rd_data));

    a_x0_kept: assert property (@(posedge clk) disable iff (rst)
        commit_valid && commit_inst[11:7] == 5'd0 |-> !commit_rd_we)
        else flag_mismatch("commit_rd_we", 64'd0, 64'($sampled(commit_rd_we)));

    initial begin
        seed     = 32'h2d86_c7a3;
        clk      = 1'b0;
        rst      = 1'b1;
        if_stall = 1'b0;
        cycles   = 0;
        fill_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (last_seen);
        @(posedge clk);
        expected_commits = accepted - $countones(accept_hist);
        if (u_rv_core.u_chk.error_count != 0) begin
            abort_run("the protocol checker reported a failed assertion");
        end else if (committed != expected_commits) begin
            flag_mismatch("commit count", 64'(expected_commits), 64'(committed));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
